// File: rtl/fmc_ctrl_cfg.svh
`ifndef FMC_CTRL_CFG_SVH
`define FMC_CTRL_CFG_SVH

// ==================================================
// Address map, adr[31:16] selects the region
// ==================================================
`define FMC_REGION_ADC_SPI 16'h0001
`define FMC_REGION_PLL_SPI 16'h0003
`define FMC_REGION_CSR     16'h0006

// Value returned by the CSR firmware ID word
`define FMC_FIRMWARE_ID 32'h01332A11

// Wishbone clocks per SPI clock half-period
`define FMC_SPI_CLK_DIV 4
`define FMC_ADC_NUM_CS  4
`define FMC_PLL_NUM_CS  1

// SPI master word offsets, adr[4:2]
`define FMC_SPI_DATA 3'd0
`define FMC_SPI_CTRL 3'd1
`define FMC_SPI_SS   3'd2

// CSR block word offsets, adr[4:2]
`define FMC_CSR_STATUS      3'd0
`define FMC_CSR_FW_ID       3'd1
`define FMC_CSR_TRIGGER     3'd2
`define FMC_CSR_ADC         3'd3
`define FMC_CSR_CLK_DISTRIB 3'd4
`define FMC_CSR_MONITOR     3'd5

`endif

// File: rtl/fmc_ctrl_pkg.sv
`default_nettype none

`include "fmc_ctrl_cfg.svh"

package fmc_ctrl_pkg;

  // ==================================================
  // Wishbone classic request and response
  // ==================================================
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] dat;
  } wb_rsp_t;

  // Card status inputs
  typedef struct packed {
    logic prsnt;
    logic pg_m2c;
    logic pll_status;
    logic mon_dev;
    logic trig_in;
  } fmc_status_t;

  // ADC sleep pin, code 3 floats as well
  typedef enum logic [1:0] {
    SLEEP_LOW   = 2'd0,
    SLEEP_HIGH  = 2'd1,
    SLEEP_FLOAT = 2'd2
  } adc_sleep_e;

  // Card control outputs
  typedef struct packed {
    logic trig_dir;
    logic trig_term;
    logic trig_val;
    logic adc_clkdivrst;
    logic adc_resetn;
    logic si571_oe;
    logic pll_function;
    logic clk_sel;
  } fmc_ctrl_t;

  // SPI bit phases, sclk low then high
  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_LEAD,
    SPI_TRAIL
  } spi_state_e;

  typedef enum logic [2:0] {
    CSR_STATUS      = `FMC_CSR_STATUS,
    CSR_FW_ID       = `FMC_CSR_FW_ID,
    CSR_TRIGGER     = `FMC_CSR_TRIGGER,
    CSR_ADC         = `FMC_CSR_ADC,
    CSR_CLK_DISTRIB = `FMC_CSR_CLK_DISTRIB,
    CSR_MONITOR     = `FMC_CSR_MONITOR
  } csr_reg_e;

endpackage

`default_nettype wire

// File: rtl/wb_region_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "fmc_ctrl_cfg.svh"

module wb_region_decode (
  input  wire logic                   wb_clk_i,
  input  wire logic                   rst_i,
  input  wire fmc_ctrl_pkg::wb_req_t  wb_i,
  input  wire fmc_ctrl_pkg::wb_rsp_t  adc_spi_rsp_i,
  input  wire fmc_ctrl_pkg::wb_rsp_t  pll_spi_rsp_i,
  input  wire fmc_ctrl_pkg::wb_rsp_t  csr_rsp_i,
  output fmc_ctrl_pkg::wb_req_t       adc_spi_req_o,
  output fmc_ctrl_pkg::wb_req_t       pll_spi_req_o,
  output fmc_ctrl_pkg::wb_req_t       csr_req_o,
  output fmc_ctrl_pkg::wb_rsp_t       wb_o
);

  logic [15:0] region;
  logic        hit_adc;
  logic        hit_pll;
  logic        hit_csr;
  logic        unmapped;
  logic        err_q;

  // Region compare on the upper half of the address
  assign region   = wb_i.adr[31:16];
  assign hit_adc  = region == `FMC_REGION_ADC_SPI;
  assign hit_pll  = region == `FMC_REGION_PLL_SPI;
  assign hit_csr  = region == `FMC_REGION_CSR;
  assign unmapped = ~(hit_adc | hit_pll | hit_csr);

  // Same request to every slave, strobe only where the region matches
  always_comb begin
    adc_spi_req_o     = wb_i;
    pll_spi_req_o     = wb_i;
    csr_req_o         = wb_i;
    adc_spi_req_o.stb = wb_i.stb & hit_adc;
    pll_spi_req_o.stb = wb_i.stb & hit_pll;
    csr_req_o.stb     = wb_i.stb & hit_csr;
  end

  // One-cycle err for unmapped regions
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= wb_i.cyc & wb_i.stb & unmapped & ~err_q;
    end
  end

  // Response merge, read data from whichever slave acked
  always_comb begin
    wb_o.ack = adc_spi_rsp_i.ack | pll_spi_rsp_i.ack | csr_rsp_i.ack;
    wb_o.err = err_q | adc_spi_rsp_i.err | pll_spi_rsp_i.err | csr_rsp_i.err;
    if (adc_spi_rsp_i.ack) begin
      wb_o.dat = adc_spi_rsp_i.dat;
    end else if (pll_spi_rsp_i.ack) begin
      wb_o.dat = pll_spi_rsp_i.dat;
    end else if (csr_rsp_i.ack) begin
      wb_o.dat = csr_rsp_i.dat;
    end else begin
      // Err and idle cycles return zero
      wb_o.dat = 32'd0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/wb_spi_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "fmc_ctrl_cfg.svh"

module wb_spi_master #(
  parameter int NUM_CS = 1
) (
  input  wire logic                  wb_clk_i,
  input  wire logic                  rst_i,
  input  wire fmc_ctrl_pkg::wb_req_t wb_i,
  output fmc_ctrl_pkg::wb_rsp_t      wb_o,
  output logic [NUM_CS-1:0]          cs_n_o,
  output logic                       sclk_o,
  output logic                       mosi_o,
  input  wire logic                  miso_i
);

  localparam int DIV   = `FMC_SPI_CLK_DIV;
  localparam int DIV_W = (DIV > 1) ? $clog2(DIV) : 1;

  fmc_ctrl_pkg::spi_state_e state_q;
  logic [DIV_W-1:0]         div_cnt_q;
  logic [5:0]               bit_cnt_q;
  logic [31:0]              data_q;
  logic [5:0]               len_q;
  logic [NUM_CS-1:0]        ss_q;
  logic                     sclk_q;
  logic                     miso_q;
  logic                     ack_q;
  logic [31:0]              rd_dat_q;
  logic                     req_hit;
  logic                     wr_en;
  logic                     busy;
  logic                     div_end;
  logic [2:0]               reg_sel;
  logic [4:0]               tx_idx;
  logic [5:0]               len_n;
  logic [5:0]               wr_len_n;
  logic [31:0]              rx_mask;

  // ==================================================
  // Bus side
  // ==================================================
  assign reg_sel = wb_i.adr[4:2];
  // No new strobe while our own ack is up
  assign req_hit = wb_i.cyc & wb_i.stb & ~ack_q;
  // Writes while shifting are acked but dropped
  assign wr_en   = req_hit & wb_i.we & ~busy;
  assign busy    = state_q != fmc_ctrl_pkg::SPI_IDLE;

  // Length field, 0 stands for 32 bits
  assign len_n    = (len_q[4:0] == 5'd0) ? 6'd32 : {1'b0, len_q[4:0]};
  assign wr_len_n = (wb_i.dat[4:0] == 5'd0) ? 6'd32 : {1'b0, wb_i.dat[4:0]};
  // First bit out sits at length-1, wraps to 31 for a 32-bit transfer
  assign tx_idx   = len_q[4:0] - 5'd1;
  assign rx_mask  = 32'hFFFF_FFFF >> (6'd32 - len_n);

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      len_q <= 6'd0;
      ss_q  <= '0;
    end else begin
      ack_q <= req_hit;
      if (wr_en && reg_sel == `FMC_SPI_CTRL) begin
        len_q <= wb_i.dat[5:0];
      end
      if (wr_en && reg_sel == `FMC_SPI_SS) begin
        ss_q <= wb_i.dat[NUM_CS-1:0];
      end
    end
  end

  // Registered read data
  always_ff @(posedge wb_clk_i) begin
    if (req_hit) begin
      case (reg_sel)
        `FMC_SPI_DATA: rd_dat_q <= data_q;
        `FMC_SPI_CTRL: rd_dat_q <= {23'd0, busy, 2'd0, len_q};
        `FMC_SPI_SS:   rd_dat_q <= 32'(ss_q);
        default:       rd_dat_q <= 32'd0;
      endcase
    end
  end

  always_comb begin
    wb_o.ack = ack_q;
    wb_o.err = 1'b0;
    wb_o.dat = rd_dat_q;
  end

  // ==================================================
  // Bit engine
  // ==================================================
  assign div_end = div_cnt_q == DIV_W'(DIV - 1);

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      state_q   <= fmc_ctrl_pkg::SPI_IDLE;
      div_cnt_q <= '0;
      bit_cnt_q <= 6'd0;
      sclk_q    <= 1'b0;
    end else begin
      case (state_q)
        fmc_ctrl_pkg::SPI_IDLE: begin
          // Go bit starts the transfer with the length in the same word
          if (wr_en && reg_sel == `FMC_SPI_CTRL && wb_i.dat[8]) begin
            state_q   <= fmc_ctrl_pkg::SPI_LEAD;
            div_cnt_q <= '0;
            bit_cnt_q <= wr_len_n;
          end
        end
        fmc_ctrl_pkg::SPI_LEAD: begin
          if (div_end) begin
            div_cnt_q <= '0;
            sclk_q    <= 1'b1;
            state_q   <= fmc_ctrl_pkg::SPI_TRAIL;
          end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
          end
        end
        fmc_ctrl_pkg::SPI_TRAIL: begin
          if (div_end) begin
            div_cnt_q <= '0;
            sclk_q    <= 1'b0;
            bit_cnt_q <= bit_cnt_q - 6'd1;
            if (bit_cnt_q == 6'd1) begin
              state_q <= fmc_ctrl_pkg::SPI_IDLE;
            end else begin
              state_q <= fmc_ctrl_pkg::SPI_LEAD;
            end
          end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
          end
        end
        default: state_q <= fmc_ctrl_pkg::SPI_IDLE;
      endcase
    end
  end

  // MISO taken on the rising sclk
  always_ff @(posedge wb_clk_i) begin
    if (state_q == fmc_ctrl_pkg::SPI_LEAD && div_end) begin
      miso_q <= miso_i;
    end
  end

  // Shift on falling sclk so MOSI moves while sclk is low
  always_ff @(posedge wb_clk_i) begin
    if (wr_en && reg_sel == `FMC_SPI_DATA) begin
      data_q <= wb_i.dat;
    end else if (state_q == fmc_ctrl_pkg::SPI_TRAIL && div_end) begin
      if (bit_cnt_q == 6'd1) begin
        // Last bit, leave the received word right-aligned
        data_q <= {data_q[30:0], miso_q} & rx_mask;
      end else begin
        data_q <= {data_q[30:0], miso_q};
      end
    end
  end

  // Pins
  assign cs_n_o = busy ? ~ss_q : '1;
  // No clock when no slave is selected
  assign sclk_o = sclk_q & (|ss_q);
  assign mosi_o = busy & data_q[tx_idx];

endmodule

`default_nettype wire

// File: rtl/fmc_csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fmc_ctrl_cfg.svh"

module fmc_csr_regs (
  input  wire logic                      wb_clk_i,
  input  wire logic                      rst_i,
  input  wire fmc_ctrl_pkg::wb_req_t     wb_i,
  output fmc_ctrl_pkg::wb_rsp_t          wb_o,
  input  wire fmc_ctrl_pkg::fmc_status_t status_i,
  output fmc_ctrl_pkg::fmc_ctrl_t        ctrl_o,
  output logic                           adc_sleep_o,
  output logic                           adc_sleep_en_o,
  output logic [2:0]                     fmc_led_o,
  output logic [2:0]                     board_led_o
);

  fmc_ctrl_pkg::fmc_ctrl_t  ctrl_q;
  fmc_ctrl_pkg::adc_sleep_e sleep_q;
  fmc_ctrl_pkg::csr_reg_e   reg_sel;
  logic [2:0]               led_q;
  logic                     ack_q;
  logic [31:0]              rd_dat_q;
  logic                     req_hit;
  logic                     wr_en;

  assign reg_sel = fmc_ctrl_pkg::csr_reg_e'(wb_i.adr[4:2]);
  assign req_hit = wb_i.cyc & wb_i.stb & ~ack_q;
  assign wr_en   = req_hit & wb_i.we;

  // ==================================================
  // Writable fields
  // ==================================================
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      ack_q   <= 1'b0;
      // Zero ctrl holds the ADC in reset
      ctrl_q  <= '0;
      sleep_q <= fmc_ctrl_pkg::SLEEP_LOW;
      led_q   <= 3'd0;
    end else begin
      ack_q <= req_hit;
      if (wr_en) begin
        case (reg_sel)
          fmc_ctrl_pkg::CSR_TRIGGER: begin
            ctrl_q.trig_dir  <= wb_i.dat[0];
            ctrl_q.trig_term <= wb_i.dat[1];
            ctrl_q.trig_val  <= wb_i.dat[2];
          end
          fmc_ctrl_pkg::CSR_ADC: begin
            ctrl_q.adc_clkdivrst <= wb_i.dat[0];
            ctrl_q.adc_resetn    <= wb_i.dat[1];
            sleep_q              <= fmc_ctrl_pkg::adc_sleep_e'(wb_i.dat[3:2]);
          end
          fmc_ctrl_pkg::CSR_CLK_DISTRIB: begin
            ctrl_q.si571_oe     <= wb_i.dat[0];
            ctrl_q.pll_function <= wb_i.dat[1];
            ctrl_q.clk_sel      <= wb_i.dat[2];
          end
          fmc_ctrl_pkg::CSR_MONITOR: begin
            led_q <= wb_i.dat[2:0];
          end
          // Status, firmware ID and holes are read-only
          default: ;
        endcase
      end
    end
  end

  // ==================================================
  // Read mux
  // ==================================================
  always_ff @(posedge wb_clk_i) begin
    if (req_hit) begin
      case (reg_sel)
        fmc_ctrl_pkg::CSR_STATUS: begin
          rd_dat_q <= {28'd0, status_i.mon_dev, status_i.pll_status,
                       status_i.pg_m2c, status_i.prsnt};
        end
        fmc_ctrl_pkg::CSR_FW_ID: begin
          rd_dat_q <= `FMC_FIRMWARE_ID;
        end
        fmc_ctrl_pkg::CSR_TRIGGER: begin
          rd_dat_q <= {29'd0, ctrl_q.trig_val, ctrl_q.trig_term, ctrl_q.trig_dir};
        end
        fmc_ctrl_pkg::CSR_ADC: begin
          rd_dat_q <= {28'd0, sleep_q, ctrl_q.adc_resetn, ctrl_q.adc_clkdivrst};
        end
        fmc_ctrl_pkg::CSR_CLK_DISTRIB: begin
          // PLL lock status shares the word with its controls
          rd_dat_q <= {28'd0, status_i.pll_status, ctrl_q.clk_sel,
                       ctrl_q.pll_function, ctrl_q.si571_oe};
        end
        fmc_ctrl_pkg::CSR_MONITOR: begin
          rd_dat_q <= {28'd0, status_i.mon_dev, led_q};
        end
        default: begin
          rd_dat_q <= 32'd0;
        end
      endcase
    end
  end

  always_comb begin
    wb_o.ack = ack_q;
    wb_o.err = 1'b0;
    wb_o.dat = rd_dat_q;
  end

  // ==================================================
  // Card pins
  // ==================================================
  assign ctrl_o = ctrl_q;

  // Float and code 3 release the pin
  assign adc_sleep_en_o = (sleep_q == fmc_ctrl_pkg::SLEEP_LOW) |
                          (sleep_q == fmc_ctrl_pkg::SLEEP_HIGH);
  assign adc_sleep_o    = sleep_q == fmc_ctrl_pkg::SLEEP_HIGH;

  // Trigger input shows up on LED 1 of the card
  assign fmc_led_o   = {led_q[2:1], led_q[0] | status_i.trig_in};
  assign board_led_o = led_q;

endmodule

`default_nettype wire

// File: rtl/fmc_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fmc_ctrl_cfg.svh"

module fmc_ctrl_top (
  input  wire logic                      wb_clk_i,
  input  wire logic                      rst_i,
  input  wire fmc_ctrl_pkg::wb_req_t     wb_i,
  output fmc_ctrl_pkg::wb_rsp_t          wb_o,
  input  wire fmc_ctrl_pkg::fmc_status_t status_i,
  output fmc_ctrl_pkg::fmc_ctrl_t        ctrl_o,
  output logic                           adc_sleep_o,
  output logic                           adc_sleep_en_o,
  output logic [2:0]                     fmc_led_o,
  output logic [2:0]                     board_led_o,
  output logic [`FMC_ADC_NUM_CS-1:0]     adc_spi_cs_n_o,
  output logic                           adc_spi_sclk_o,
  output logic                           adc_spi_mosi_o,
  input  wire logic                      adc_spi_miso_i,
  output logic [`FMC_PLL_NUM_CS-1:0]     pll_spi_cs_n_o,
  output logic                           pll_spi_sclk_o,
  output logic                           pll_spi_mosi_o,
  input  wire logic                      pll_spi_miso_i
);

  fmc_ctrl_pkg::wb_req_t adc_spi_req;
  fmc_ctrl_pkg::wb_req_t pll_spi_req;
  fmc_ctrl_pkg::wb_req_t csr_req;
  fmc_ctrl_pkg::wb_rsp_t adc_spi_rsp;
  fmc_ctrl_pkg::wb_rsp_t pll_spi_rsp;
  fmc_ctrl_pkg::wb_rsp_t csr_rsp;

  // ==================================================
  // Region decode
  // ==================================================
  wb_region_decode i_decode (
    .wb_clk_i      (wb_clk_i),
    .rst_i         (rst_i),
    .wb_i          (wb_i),
    .adc_spi_rsp_i (adc_spi_rsp),
    .pll_spi_rsp_i (pll_spi_rsp),
    .csr_rsp_i     (csr_rsp),
    .adc_spi_req_o (adc_spi_req),
    .pll_spi_req_o (pll_spi_req),
    .csr_req_o     (csr_req),
    .wb_o          (wb_o)
  );

  // ISLA216P ADCs, region 0x0001
  wb_spi_master #(
    .NUM_CS (`FMC_ADC_NUM_CS)
  ) i_adc_spi (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .wb_i     (adc_spi_req),
    .wb_o     (adc_spi_rsp),
    .cs_n_o   (adc_spi_cs_n_o),
    .sclk_o   (adc_spi_sclk_o),
    .mosi_o   (adc_spi_mosi_o),
    .miso_i   (adc_spi_miso_i)
  );

  // AD9510 clock PLL, region 0x0003
  wb_spi_master #(
    .NUM_CS (`FMC_PLL_NUM_CS)
  ) i_pll_spi (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .wb_i     (pll_spi_req),
    .wb_o     (pll_spi_rsp),
    .cs_n_o   (pll_spi_cs_n_o),
    .sclk_o   (pll_spi_sclk_o),
    .mosi_o   (pll_spi_mosi_o),
    .miso_i   (pll_spi_miso_i)
  );

  // Card control and status, region 0x0006
  fmc_csr_regs i_csr (
    .wb_clk_i       (wb_clk_i),
    .rst_i          (rst_i),
    .wb_i           (csr_req),
    .wb_o           (csr_rsp),
    .status_i       (status_i),
    .ctrl_o         (ctrl_o),
    .adc_sleep_o    (adc_sleep_o),
    .adc_sleep_en_o (adc_sleep_en_o),
    .fmc_led_o      (fmc_led_o),
    .board_led_o    (board_led_o)
  );

endmodule

`default_nettype wire

// File: dv/fmc_ctrl_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "fmc_ctrl_cfg.svh"

module fmc_ctrl_asserts (
  input wire logic                         wb_clk_i,
  input wire logic                         rst_i,
  input wire fmc_ctrl_pkg::wb_req_t        wb_i,
  input wire fmc_ctrl_pkg::wb_rsp_t        wb_o,
  input wire logic [`FMC_ADC_NUM_CS-1:0]   adc_cs_n_i,
  input wire logic                         adc_sclk_i,
  input wire logic [`FMC_PLL_NUM_CS-1:0]   pll_cs_n_i,
  input wire logic                         pll_sclk_i
);

  // Assertion failures so far
  int fail_cnt = 0;

  // ==================================================
  // Bus response
  // ==================================================
  a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    !(wb_o.ack && wb_o.err))
    else begin
      fail_cnt++;
      $error("ack and err high together");
    end

  a_ack_single: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    wb_o.ack |=> !wb_o.ack)
    else begin
      fail_cnt++;
      $error("ack high for two cycles");
    end

  // ==================================================
  // SPI pins
  // ==================================================
  // Idle bus never selects a slave, only an acked write starts a transfer
  a_adc_cs_idle: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    $fell(&adc_cs_n_i) |-> (wb_o.ack && $past(wb_i.we)))
    else begin
      fail_cnt++;
      $error("ADC chip select fell without a bus write");
    end

  a_pll_cs_idle: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    $fell(&pll_cs_n_i) |-> (wb_o.ack && $past(wb_i.we)))
    else begin
      fail_cnt++;
      $error("PLL chip select fell without a bus write");
    end

  // No clock with every slave deselected
  a_adc_sclk_quiet: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (&adc_cs_n_i && $past(&adc_cs_n_i)) |-> $stable(adc_sclk_i))
    else begin
      fail_cnt++;
      $error("ADC sclk toggled while deselected");
    end

  a_pll_sclk_quiet: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (&pll_cs_n_i && $past(&pll_cs_n_i)) |-> $stable(pll_sclk_i))
    else begin
      fail_cnt++;
      $error("PLL sclk toggled while deselected");
    end

endmodule

bind fmc_ctrl_top fmc_ctrl_asserts i_asserts (
  .wb_clk_i   (wb_clk_i),
  .rst_i      (rst_i),
  .wb_i       (wb_i),
  .wb_o       (wb_o),
  .adc_cs_n_i (adc_spi_cs_n_o),
  .adc_sclk_i (adc_spi_sclk_o),
  .pll_cs_n_i (pll_spi_cs_n_o),
  .pll_sclk_i (pll_spi_sclk_o)
);

`default_nettype wire

// File: dv/tb_fmc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fmc_ctrl_cfg.svh"

module tb_fmc_ctrl;

  localparam int BIT_CYC = 2 * `FMC_SPI_CLK_DIV;
  localparam int N_CSR   = 40;
  localparam int N_SPI   = 12;
  localparam int N_UNMAP = 16;
  // Test items plus the register sweep reads, each allowed a full 32-bit transfer
  localparam int N_TXN   = N_CSR + 2 * N_SPI + 1 + N_UNMAP + 3 * 7 + 1;

  logic                        wb_clk_i;
  logic                        rst_i;
  fmc_ctrl_pkg::wb_req_t       wb_req;
  fmc_ctrl_pkg::wb_rsp_t       wb_rsp;
  fmc_ctrl_pkg::fmc_status_t   status;
  fmc_ctrl_pkg::fmc_ctrl_t     ctrl;
  logic                        adc_sleep;
  logic                        adc_sleep_en;
  logic [2:0]                  fmc_led;
  logic [2:0]                  board_led;
  logic [`FMC_ADC_NUM_CS-1:0]  adc_cs_n;
  logic                        adc_sclk;
  logic                        adc_mosi;
  logic                        adc_miso;
  logic [`FMC_PLL_NUM_CS-1:0]  pll_cs_n;
  logic                        pll_sclk;
  logic                        pll_mosi;
  logic                        pll_miso;

  int seed = 32'hc273_3345;

  // Reference register image
  logic [2:0] m_trig;
  logic [3:0] m_adc;
  logic [2:0] m_clk;
  logic [2:0] m_led;

  // SPI slave model state
  logic [31:0]                adc_rx_word;
  logic [31:0]                adc_tx_cap;
  logic [`FMC_ADC_NUM_CS-1:0] adc_cs_cap;
  int                         adc_rise;
  logic [31:0]                pll_rx_word;
  logic [31:0]                pll_tx_cap;
  logic [`FMC_PLL_NUM_CS-1:0] pll_cs_cap;
  int                         pll_rise;

  fmc_ctrl_top i_dut (
    .wb_clk_i       (wb_clk_i),
    .rst_i          (rst_i),
    .wb_i           (wb_req),
    .wb_o           (wb_rsp),
    .status_i       (status),
    .ctrl_o         (ctrl),
    .adc_sleep_o    (adc_sleep),
    .adc_sleep_en_o (adc_sleep_en),
    .fmc_led_o      (fmc_led),
    .board_led_o    (board_led),
    .adc_spi_cs_n_o (adc_cs_n),
    .adc_spi_sclk_o (adc_sclk),
    .adc_spi_mosi_o (adc_mosi),
    .adc_spi_miso_i (adc_miso),
    .pll_spi_cs_n_o (pll_cs_n),
    .pll_spi_sclk_o (pll_sclk),
    .pll_spi_mosi_o (pll_mosi),
    .pll_spi_miso_i (pll_miso)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #2 wb_clk_i = ~wb_clk_i;
  end

  // ==================================================
  // SPI slave models
  // ==================================================
  // MISO word goes out MSB first, one bit per rising sclk
  assign adc_miso = (adc_rise < 32) ? adc_rx_word[31 - adc_rise] : 1'b0;
  assign pll_miso = (pll_rise < 32) ? pll_rx_word[31 - pll_rise] : 1'b0;

  always @(posedge adc_sclk) begin
    if (adc_cs_n != '1) begin
      adc_tx_cap = {adc_tx_cap[30:0], adc_mosi};
      adc_cs_cap = adc_cs_n;
      adc_rise++;
    end
  end

  always @(posedge pll_sclk) begin
    if (pll_cs_n != '1) begin
      pll_tx_cap = {pll_tx_cap[30:0], pll_mosi};
      pll_cs_cap = pll_cs_n;
      pll_rise++;
    end
  end

  // ==================================================
  // Checks
  // ==================================================
  task automatic stop_on_error();
    $display("ERRORS FOUND");
    $fatal(1, "first mismatch, run stopped");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_ctrl(input string name, input fmc_ctrl_pkg::fmc_ctrl_t exp,
                            input fmc_ctrl_pkg::fmc_ctrl_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      stop_on_error();
    end
  endtask

  // Pins compared as {enable, level}
  task automatic check_sleep(input string name, input fmc_ctrl_pkg::adc_sleep_e exp);
    logic [1:0] exp_pins;
    logic [1:0] act_pins;
    exp_pins[1] = (exp == fmc_ctrl_pkg::SLEEP_LOW) || (exp == fmc_ctrl_pkg::SLEEP_HIGH);
    exp_pins[0] = exp == fmc_ctrl_pkg::SLEEP_HIGH;
    act_pins    = {adc_sleep_en, adc_sleep};
    if (act_pins !== exp_pins) begin
      $display("Fail %s: expected %b, actual %b", name, exp_pins, act_pins);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      stop_on_error();
    end
  endtask

  // ==================================================
  // Bus master
  // ==================================================
  function automatic logic [31:0] reg_adr(input logic [15:0] region, input logic [2:0] off);
    return {region, 11'd0, off, 2'b00};
  endfunction

  // Called 1 ns after a rising edge, returns at the same point
  task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat, output logic ack, output logic err);
    int n_cyc;
    n_cyc      = 0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    do begin
      @(posedge wb_clk_i);
      #1;
      n_cyc++;
    end while (!wb_rsp.ack && !wb_rsp.err);
    rdat       = wb_rsp.dat;
    ack        = wb_rsp.ack;
    err        = wb_rsp.err;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    check_word("response latency", 32'd1, n_cyc);
    // Bus idle for one cycle
    @(posedge wb_clk_i);
    #1;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] wdat);
    logic [31:0] rdat;
    logic        ack;
    logic        err;
    wb_access(1'b1, adr, wdat, rdat, ack, err);
    check_bit("write ack", 1'b1, ack);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] rdat);
    logic ack;
    logic err;
    wb_access(1'b0, adr, 32'd0, rdat, ack, err);
    check_bit("read ack", 1'b1, ack);
  endtask

  // ==================================================
  // Reference model comparisons
  // ==================================================
  task automatic check_outputs(input string name);
    fmc_ctrl_pkg::fmc_ctrl_t exp;
    exp.trig_dir      = m_trig[0];
    exp.trig_term     = m_trig[1];
    exp.trig_val      = m_trig[2];
    exp.adc_clkdivrst = m_adc[0];
    exp.adc_resetn    = m_adc[1];
    exp.si571_oe      = m_clk[0];
    exp.pll_function  = m_clk[1];
    exp.clk_sel       = m_clk[2];
    check_ctrl(name, exp, ctrl);
    check_sleep(name, fmc_ctrl_pkg::adc_sleep_e'(m_adc[3:2]));
    check_word({name, " fmc led"}, {29'd0, m_led[2:1], m_led[0] | status.trig_in},
               {29'd0, fmc_led});
    check_word({name, " board led"}, {29'd0, m_led}, {29'd0, board_led});
  endtask

  task automatic check_regs();
    logic [31:0] rdat;
    wb_read(reg_adr(`FMC_REGION_CSR, `FMC_CSR_STATUS), rdat);
    check_word("status", {28'd0, status.mon_dev, status.pll_status, status.pg_m2c,
                          status.prsnt}, rdat);
    wb_read(reg_adr(`FMC_REGION_CSR, `FMC_CSR_FW_ID), rdat);
    check_word("firmware id", `FMC_FIRMWARE_ID, rdat);
    wb_read(reg_adr(`FMC_REGION_CSR, `FMC_CSR_TRIGGER), rdat);
    check_word("trigger", {29'd0, m_trig}, rdat);
    wb_read(reg_adr(`FMC_REGION_CSR, `FMC_CSR_ADC), rdat);
    check_word("adc", {28'd0, m_adc}, rdat);
    wb_read(reg_adr(`FMC_REGION_CSR, `FMC_CSR_CLK_DISTRIB), rdat);
    check_word("clk distrib", {28'd0, status.pll_status, m_clk}, rdat);
    wb_read(reg_adr(`FMC_REGION_CSR, `FMC_CSR_MONITOR), rdat);
    check_word("monitor", {28'd0, status.mon_dev, m_led}, rdat);
    wb_read(reg_adr(`FMC_REGION_CSR, 3'd6), rdat);
    check_word("csr hole", 32'd0, rdat);
  endtask

  // ==================================================
  // SPI transfer
  // ==================================================
  task automatic spi_transfer(input logic [15:0] region, input logic [3:0] mask,
                              input int len, input logic [31:0] tx, input bit disturb);
    logic [31:0] rdat;
    logic [31:0] len_mask;
    logic [31:0] rx_word;
    logic [31:0] tx_cap;
    logic [3:0]  cs_cap;
    int          rise;
    len_mask    = 32'hFFFF_FFFF >> (32 - len);
    adc_rx_word = $random(seed);
    pll_rx_word = $random(seed);
    adc_rise    = 0;
    pll_rise    = 0;
    adc_tx_cap  = 32'd0;
    pll_tx_cap  = 32'd0;
    wb_write(reg_adr(region, `FMC_SPI_SS), {28'd0, mask});
    wb_write(reg_adr(region, `FMC_SPI_DATA), tx);
    wb_write(reg_adr(region, `FMC_SPI_CTRL), {23'd0, 1'b1, 2'd0, 6'(len % 32)});
    if (disturb) begin
      // Dropped while the transfer runs
      wb_write(reg_adr(region, `FMC_SPI_DATA), ~tx);
      wb_write(reg_adr(region, `FMC_SPI_SS), 32'd0);
    end
    do begin
      wb_read(reg_adr(region, `FMC_SPI_CTRL), rdat);
    end while (rdat[8]);
    if (region == `FMC_REGION_PLL_SPI) begin
      rx_word = pll_rx_word;
      tx_cap  = pll_tx_cap;
      cs_cap  = {3'b111, pll_cs_cap};
      rise    = pll_rise;
    end else begin
      rx_word = adc_rx_word;
      tx_cap  = adc_tx_cap;
      cs_cap  = adc_cs_cap;
      rise    = adc_rise;
    end
    check_word("spi mosi bits", tx & len_mask, tx_cap & len_mask);
    check_word("spi edge count", len, rise);
    check_word("spi chip select", {28'd0, ~mask}, {28'd0, cs_cap});
    wb_read(reg_adr(region, `FMC_SPI_DATA), rdat);
    check_word("spi rx data", rx_word >> (32 - len), rdat);
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    logic [31:0] rdat;
    logic [31:0] wdat;
    logic [31:0] adr;
    logic [15:0] region;
    logic [3:0]  mask;
    logic        ack;
    logic        err;
    int          idx;
    int          len;

    rst_i    = 1'b1;
    wb_req   = '0;
    status   = fmc_ctrl_pkg::fmc_status_t'($random(seed));
    m_trig   = 3'd0;
    m_adc    = 4'd0;
    m_clk    = 3'd0;
    m_led    = 3'd0;
    repeat (8) @(posedge wb_clk_i);
    #1;
    rst_i = 1'b0;

    // Reset values
    check_outputs("reset");
    check_word("reset adc cs", 32'hF, {28'd0, adc_cs_n});
    check_bit("reset pll cs", 1'b1, pll_cs_n[0]);
    check_bit("reset adc sclk", 1'b0, adc_sclk);
    check_regs();
    wb_read(reg_adr(`FMC_REGION_ADC_SPI, `FMC_SPI_CTRL), rdat);
    check_word("reset busy", 32'd0, rdat);

    // Random CSR writes with masking
    for (int i = 0; i < N_CSR; i++) begin
      idx  = $random(seed) & 3;
      wdat = $random(seed);
      status.trig_in = 1'($random(seed));
      wb_write(reg_adr(`FMC_REGION_CSR, 3'(idx + 2)), wdat);
      case (idx)
        0: m_trig = wdat[2:0];
        1: m_adc  = wdat[3:0];
        2: m_clk  = wdat[2:0];
        default: m_led = wdat[2:0];
      endcase
      check_outputs("csr write");
      wb_read(reg_adr(`FMC_REGION_CSR, 3'(idx + 2)), rdat);
      case (idx)
        0: check_word("trigger readback", {29'd0, m_trig}, rdat);
        1: check_word("adc readback", {28'd0, m_adc}, rdat);
        2: check_word("clk distrib readback", {28'd0, status.pll_status, m_clk}, rdat);
        default: check_word("monitor readback", {28'd0, status.mon_dev, m_led}, rdat);
      endcase
    end
    check_regs();

    // SPI on both masters, the last few disturbed while busy
    for (int i = 0; i < 2 * N_SPI; i++) begin
      len  = ($random(seed) & 31) + 1;
      wdat = $random(seed);
      if (i % 2 == 1) begin
        region = `FMC_REGION_PLL_SPI;
        mask   = 4'd1;
      end else begin
        region = `FMC_REGION_ADC_SPI;
        mask   = 4'($random(seed));
        if (mask == 4'd0) begin
          mask = 4'd8;
        end
      end
      spi_transfer(region, mask, len, wdat, i >= 2 * N_SPI - 6);
    end
    spi_transfer(`FMC_REGION_ADC_SPI, 4'd1, 32, $random(seed), 1'b0);

    // Unmapped regions, the holes between mapped ones first
    for (int i = 0; i < N_UNMAP; i++) begin
      case (i)
        0: region = 16'h0002;
        1: region = 16'h0004;
        2: region = 16'h0005;
        default: region = 16'($random(seed));
      endcase
      if (region == `FMC_REGION_ADC_SPI || region == `FMC_REGION_PLL_SPI ||
          region == `FMC_REGION_CSR) begin
        region = region ^ 16'h8000;
      end
      adr = {region, 16'($random(seed))};
      wb_access(1'($random(seed)), adr, $random(seed), rdat, ack, err);
      check_bit("unmapped err", 1'b1, err);
      check_bit("unmapped ack", 1'b0, ack);
      check_word("unmapped rdata", 32'd0, rdat);
    end
    check_outputs("after unmapped");
    check_regs();

    if (i_dut.i_asserts.fail_cnt == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("ERRORS FOUND");
      $fatal(1, "bound assertions failed");
    end
  end

  // Watchdog
  initial begin
    repeat (N_TXN * (BIT_CYC * 32 + 20)) @(posedge wb_clk_i);
    $display("Timeout: the tests did not finish in the allowed time");
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
rtl/fmc_ctrl_pkg.sv
rtl/wb_region_decode.sv
rtl/wb_spi_master.sv
rtl/fmc_csr_regs.sv
rtl/fmc_ctrl_top.sv
dv/fmc_ctrl_asserts.sv
dv/tb_fmc_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the FMC control plane testbench with Verilator
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f vlog.f \
       --top-module tb_fmc_ctrl -o sim_fmc_ctrl \
  && ./obj_dir/sim_fmc_ctrl \
  || { echo "simulation failed"; exit 1; }
